//--- common/cpu_pkg.sv
// shared definitions for the 16-bit five-stage pipelined processor
// widths, instruction encodings, flags and the payloads passed between stages
// every RTL file refers to these by scoped name
package cpu_pkg;

    localparam int WORD_SIZE   = 16;
    localparam int REG_BITS    = 3;
    localparam int NUM_REGS    = 8;
    localparam int OPCODE_BITS = 3;
    localparam int IMM_BITS    = 9;

    typedef logic [WORD_SIZE-1:0] word_t;
    typedef logic [REG_BITS-1:0]  reg_idx_t;

    // opcode field, bits 15:13 of the instruction word
    typedef enum logic [OPCODE_BITS-1:0] {
        OP_MV  = 3'b000,
        OP_BCC = 3'b001,
        OP_ADD = 3'b010,
        OP_SUB = 3'b011,
        OP_LD  = 3'b100,
        OP_ST  = 3'b101,
        OP_CMP = 3'b111
    } opcode_t;

    // branch condition, carried in the rX field of a bcc
    typedef enum logic [2:0] {
        COND_NONE = 3'd0,
        COND_EQ   = 3'd1,
        COND_NE   = 3'd2,
        COND_CC   = 3'd3,
        COND_CS   = 3'd4,
        COND_PL   = 3'd5,
        COND_MI   = 3'd6
    } cond_t;

    typedef enum logic [1:0] {
        ALU_PASS = 2'd0,
        ALU_ADD  = 2'd1,
        ALU_SUB  = 2'd2
    } alu_op_t;

    typedef struct packed {
        logic negative;
        logic zero;
        logic carry; // borrow after cmp
    } flags_t;

    // decode stage register, input of execute
    typedef struct packed {
        logic     valid;
        alu_op_t  alu_op;
        word_t    op1;
        word_t    op2;
        reg_idx_t rx;
        logic     writeback;
        logic     read;
        logic     write;
        logic     update_flags;
        cond_t    cond;
        logic     is_branch;
    } decoded_t;

    // execute and memory stage registers
    typedef struct packed {
        logic     valid;
        logic     is_branch;
        logic     writeback;
        reg_idx_t rx;
        logic     read;
        logic     write;
        word_t    result;     // alu result, or data address for ld/st
        word_t    store_data;
    } stage_t;

endpackage

//--- filelist.f
common/cpu_pkg.sv
src/register_file.sv
src/fetch_unit.sv
src/instr_decoder.sv
src/hazard_unit.sv
src/execute_unit.sv
src/memory_stage.sv
src/cpu_top.sv
sim/cpu_tb.sv

//--- sim/cpu_tb.sv
// testbench for the pipelined processor top level
// runs short generated programs, predicts every store with an instruction-set model
// and checks the data bus with assertions; the data memory answers after 0 to 3 cycles
`timescale 1ns/10ps

module cpu_tb;

    localparam cpu_pkg::word_t END_ADDR = 16'hFFFF; // last store of every program

    logic           Clock = 1'b0;
    logic           Reset;
    cpu_pkg::word_t InstrIn;
    cpu_pkg::word_t DataIn;
    logic           DataDone;
    cpu_pkg::word_t InstrAddr;
    cpu_pkg::word_t DataAddr;
    cpu_pkg::word_t DataOut;
    logic           ReadData;
    logic           WriteData;

    cpu_pkg::word_t prog [256];
    cpu_pkg::word_t dmem [cpu_pkg::word_t];    // bus model memory
    cpu_pkg::word_t iss_mem [cpu_pkg::word_t]; // reference model memory
    cpu_pkg::word_t exp_addr [$];
    cpu_pkg::word_t exp_data [$];
    cpu_pkg::word_t exp_pc [$];                // distinct fetch addresses in order
    cpu_pkg::word_t last_iaddr = '0;
    int   pc_idx = 0;
    int   plen;
    int   st_idx;
    int   errors = 0;
    int   test_err0;
    int   passed = 0;
    int   failed = 0;
    int   cycles = 0;
    int   budget = 8;
    int   delay;
    logic active;
    logic end_seen;

    cpu_top UUT (
        .Clock(Clock), .Reset(Reset), .InstrIn(InstrIn), .DataIn(DataIn),
        .DataDone(DataDone), .InstrAddr(InstrAddr), .DataAddr(DataAddr),
        .DataOut(DataOut), .ReadData(ReadData), .WriteData(WriteData)
    );

    always #20 Clock = ~Clock;

    assign InstrIn = prog[InstrAddr[7:0]]; // combinational instruction memory

    always @(posedge Clock) begin
        cycles++;
        if (cycles > budget) begin
            $display("watchdog: no end of program after %0d cycles", budget);
            $display("Simulation FAILED");
            $finish;
        end
    end

    assert property (@(posedge Clock) disable iff (Reset) !(ReadData && WriteData))
        else begin
            $display("ReadData and WriteData were high in the same cycle");
            errors++;
        end

    // bus levels hold until the cycle with DataDone
    assert property (@(posedge Clock) disable iff (Reset)
        (ReadData || WriteData) && !DataDone |=> $stable(DataAddr) && $stable(DataOut) &&
        $stable(ReadData) && $stable(WriteData))
        else begin
            $display("data bus changed while the access waited for DataDone");
            errors++;
        end

    function automatic cpu_pkg::word_t fill(input cpu_pkg::word_t a);
        return (a * 16'h9E37) ^ 16'h5AC3;
    endfunction

    task automatic check_word(input string name, input cpu_pkg::word_t got,
                              input cpu_pkg::word_t exp);
        assert (got === exp) else begin
            $display("error %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // compare one completed store with the next predicted one
    task automatic record_store();
        assert (st_idx < exp_addr.size()) else begin
            $display("store to address %h that the model does not predict", DataAddr);
            errors++;
        end
        if (st_idx < exp_addr.size()) begin
            check_word("DataAddr", DataAddr, exp_addr[st_idx]);
            check_word("DataOut", DataOut, exp_data[st_idx]);
            st_idx++;
        end
        dmem[DataAddr] = DataOut;
        if (DataAddr == END_ADDR) end_seen = 1'b1;
    endtask

    // each new instruction address is compared with the model's fetch order
    always @(negedge Clock) begin
        if (!Reset && InstrAddr !== last_iaddr) begin
            if (pc_idx < exp_pc.size()) begin
                check_word("InstrAddr", InstrAddr, exp_pc[pc_idx]);
                pc_idx++;
            end
            last_iaddr = InstrAddr;
        end
    end

    // data memory with random wait states, driven on the falling edge
    always @(negedge Clock) begin
        if (Reset) begin
            DataDone = 1'b0;
            active   = 1'b0;
        end else begin
            if (DataDone) active = 1'b0; // previous access ended at the last edge
            DataDone = 1'b0;
            DataIn   = $urandom;
            if ((ReadData || WriteData) && !active) begin
                active = 1'b1;
                delay  = $urandom_range(3, 0);
            end
            if (active && delay == 0) begin
                DataDone = 1'b1;
                if (ReadData) DataIn = dmem.exists(DataAddr) ? dmem[DataAddr] : fill(DataAddr);
                if (WriteData) record_store();
            end else if (active) begin
                delay--;
            end
        end
    end

    // instruction-set model, runs the program in order and lists its stores
    task automatic run_model();
        cpu_pkg::word_t r [8];
        cpu_pkg::word_t w;
        cpu_pkg::word_t op2;
        logic [16:0]    diff;
        logic [2:0]     op;
        logic [2:0]     rx;
        logic           fn, fz, fc, take, done;
        int             pc;
        exp_addr.delete();
        exp_data.delete();
        exp_pc.delete();
        iss_mem.delete();
        for (int i = 0; i < 8; i++) r[i] = '0;
        {fn, fz, fc, done} = 4'b0;
        pc = 0;
        while (!done && pc < plen) begin
            w   = prog[pc];
            op  = w[15:13];
            rx  = w[11:9];
            op2 = w[12] ? {{7{w[8]}}, w[8:0]} : r[w[2:0]];
            if (exp_pc.size() == 0 || exp_pc[$] != 16'(pc)) exp_pc.push_back(16'(pc));
            pc++;
            if (w != '0 && op != 3'b110 && !(op == 3'b111 && !w[12] && w[8:3] != '0)) begin
                case (op)
                    3'b000: r[rx] = op2;
                    3'b010: r[rx] = r[rx] + op2;
                    3'b011: r[rx] = r[rx] - op2;
                    3'b100: r[rx] = iss_mem.exists(op2) ? iss_mem[op2] : fill(op2);
                    3'b101: begin
                        iss_mem[op2] = r[rx];
                        exp_addr.push_back(op2);
                        exp_data.push_back(r[rx]);
                        done = (op2 == END_ADDR);
                    end
                    3'b111: begin
                        diff = {1'b0, r[rx]} - {1'b0, op2};
                        fz   = (diff[15:0] == '0);
                        fn   = diff[15];
                        fc   = diff[16]; // borrow
                    end
                    default: begin
                        case (rx)
                            3'd1:    take = fz;
                            3'd2:    take = !fz;
                            3'd3:    take = !fc;
                            3'd4:    take = fc;
                            3'd5:    take = !fz && !fn;
                            3'd6:    take = !fz && fn;
                            default: take = 1'b1;
                        endcase
                        if (take) begin
                            exp_pc.push_back(16'(pc)); // fetch sits here until resolved
                            pc = pc + $signed(w[8:0]);
                        end
                    end
                endcase
            end
        end
    endtask

    task automatic emit_i(input logic [2:0] op, input logic [2:0] rx, input logic [8:0] imm);
        prog[plen] = {op, 1'b1, rx, imm};
        plen++;
    endtask

    task automatic emit_r(input logic [2:0] op, input logic [2:0] rx, input logic [2:0] ry);
        prog[plen] = {op, 1'b0, rx, 6'b0, ry};
        plen++;
    endtask

    function automatic logic [2:0] alu_pick(input logic [1:0] sel);
        case (sel)
            2'd0:    return cpu_pkg::OP_MV;
            2'd1:    return cpu_pkg::OP_ADD;
            default: return cpu_pkg::OP_SUB;
        endcase
    endfunction

    task automatic store_all(input logic [8:0] base);
        for (int i = 0; i < 8; i++) emit_i(cpu_pkg::OP_ST, 3'(i), base + 9'(i));
    endtask

    task automatic random_regs();
        logic [31:0] rnd;
        for (int i = 0; i < 8; i++) begin
            rnd = $urandom;
            emit_i(cpu_pkg::OP_MV, 3'(i), rnd[8:0]);
        end
    endtask

    task automatic begin_test();
        @(negedge Clock);
        Reset     = 1'b1; // program changes only while the DUT is held
        test_err0 = errors;
        for (int i = 0; i < 256; i++) prog[i] = '0;
        plen = 0;
    endtask

    task automatic report(input string name);
        if (errors == test_err0) begin
            passed++;
            $display("test %-20s passed, %0d stores checked", name, st_idx);
        end else begin
            failed++;
            $display("test %-20s failed with %0d errors", name, errors - test_err0);
        end
    endtask

    task automatic end_test(input string name);
        emit_i(cpu_pkg::OP_ST, 3'd0, 9'h1FF);              // end marker store
        emit_i(cpu_pkg::OP_BCC, cpu_pkg::COND_NONE, 9'h1FF); // spin on itself
        run_model();
        dmem.delete();
        st_idx     = 0;
        end_seen   = 1'b0;
        last_iaddr = '0;
        pc_idx     = 1;  // address 0 is presented out of reset
        budget     = budget + plen * 20;
        repeat (2) @(negedge Clock);
        Reset = 1'b0;
        while (!end_seen) @(posedge Clock);
        assert (st_idx == exp_addr.size()) else begin
            $display("only %0d of %0d predicted stores seen", st_idx, exp_addr.size());
            errors++;
        end
        assert (pc_idx == exp_pc.size()) else begin
            $display("only %0d of %0d predicted fetch addresses seen", pc_idx, exp_pc.size());
            errors++;
        end
        report(name);
    endtask

    initial begin
        logic [31:0] rnd;
        logic [2:0]  prev;
        Reset    = 1'b0;
        DataIn   = '0;
        DataDone = 1'b0;
        void'($urandom(29051));
        for (int i = 0; i < 256; i++) prog[i] = '0;
        #1 Reset = 1'b1;
        #1;
        test_err0 = errors;
        st_idx    = 0;
        for (int pass = 0; pass < 2; pass++) begin
            check_word("InstrAddr", InstrAddr, '0);
            check_word("DataAddr", DataAddr, '0);
            check_word("DataOut", DataOut, '0);
            check_word("ReadData", {15'b0, ReadData}, '0);
            check_word("WriteData", {15'b0, WriteData}, '0);
            if (pass == 0) begin
                repeat (2) @(negedge Clock);
                Reset = 1'b0;
                #1;
            end
        end
        report("reset values");

        begin_test();
        random_regs();
        for (int k = 0; k < 24; k++) begin
            rnd = $urandom;
            if (rnd[20])
                emit_i(alu_pick(rnd[19:18]), rnd[2:0], rnd[11:3]);
            else
                emit_r(alu_pick(rnd[19:18]), rnd[2:0], rnd[5:3]);
        end
        store_all(9'h010);
        end_test("alu and immediates");

        begin_test();
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 1; i < 8; i++) begin
                rnd = $urandom;
                emit_i(cpu_pkg::OP_LD, 3'(i), rnd[8:0]);
            end
            emit_r(cpu_pkg::OP_LD, 3'd0, 3'd1); // address from a loaded value
            emit_r(cpu_pkg::OP_ADD, 3'd1, 3'd2);
            emit_r(cpu_pkg::OP_ADD, 3'd3, 3'd4);
            emit_r(cpu_pkg::OP_SUB, 3'd5, 3'd6);
            emit_r(cpu_pkg::OP_ADD, 3'd7, 3'd0);
            store_all(9'h020 + 9'(pass * 8));
        end
        end_test("loads with wait states");

        begin_test();
        random_regs();
        prev = 3'd0;
        for (int k = 0; k < 24; k++) begin
            rnd = $urandom;
            if (rnd[1]) begin
                emit_i(rnd[0] ? cpu_pkg::OP_ADD : cpu_pkg::OP_SUB, prev, rnd[12:4]);
            end else begin
                emit_r(rnd[0] ? cpu_pkg::OP_ADD : cpu_pkg::OP_SUB, rnd[15:13], prev);
                prev = rnd[15:13];
            end
        end
        store_all(9'h030);
        end_test("dependent chains");

        begin_test();
        for (int t = 0; t < 14; t++) begin
            rnd = $urandom;
            emit_i(cpu_pkg::OP_MV, 3'd1, rnd[8:0]);
            emit_i(cpu_pkg::OP_MV, 3'd2, rnd[20] ? rnd[8:0] : rnd[17:9]); // equal at times
            emit_i(cpu_pkg::OP_MV, 3'd3, 9'(t));
            if (rnd[21]) emit_r(cpu_pkg::OP_CMP, 3'd1, 3'd2);
            else emit_i(cpu_pkg::OP_CMP, 3'd1, rnd[17:9]);
            emit_i(cpu_pkg::OP_BCC, 3'(t % 7), 9'd1);
            emit_i(cpu_pkg::OP_ST, 3'd3, 9'h040 + 9'(t)); // marker, skipped when taken
        end
        end_test("cmp and branches");

        begin_test();
        emit_i(cpu_pkg::OP_MV, 3'd1, 9'd5);
        emit_i(cpu_pkg::OP_BCC, cpu_pkg::COND_NONE, 9'd2);
        emit_i(cpu_pkg::OP_ST, 3'd1, 9'h080);
        emit_i(cpu_pkg::OP_ST, 3'd1, 9'h081);
        emit_i(cpu_pkg::OP_CMP, 3'd1, 9'd5);
        emit_i(cpu_pkg::OP_BCC, cpu_pkg::COND_EQ, 9'd1);
        emit_i(cpu_pkg::OP_ST, 3'd1, 9'h082);
        emit_i(cpu_pkg::OP_BCC, cpu_pkg::COND_NE, 9'd1);
        emit_i(cpu_pkg::OP_ST, 3'd1, 9'h083);
        emit_i(cpu_pkg::OP_LD, 3'd4, 9'h033);
        emit_i(cpu_pkg::OP_BCC, cpu_pkg::COND_NONE, 9'd1);
        emit_r(cpu_pkg::OP_LD, 3'd5, 3'd4);
        emit_i(cpu_pkg::OP_ST, 3'd4, 9'h085);
        end_test("wrong path");

        $display("%0d tests passed, %0d failed, %0d errors", passed, failed, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- src/cpu_top.sv
// top level of the five-stage pipelined processor
// connects fetch, decode, execute and memory stages with the register file
// and the hazard logic; instruction and data buses go straight to the pins
`timescale 1ns/10ps

module cpu_top (
    input  logic           Clock,
    input  logic           Reset,
    input  cpu_pkg::word_t InstrIn,
    input  cpu_pkg::word_t DataIn,
    input  logic           DataDone,
    output cpu_pkg::word_t InstrAddr,
    output cpu_pkg::word_t DataAddr,
    output cpu_pkg::word_t DataOut,
    output logic           ReadData,
    output logic           WriteData
);

    cpu_pkg::word_t    fetch_word;
    cpu_pkg::word_t    fetch_pc;
    cpu_pkg::reg_idx_t rf_raddr_a;
    cpu_pkg::reg_idx_t rf_raddr_b;
    cpu_pkg::word_t    rf_rdata_a;
    cpu_pkg::word_t    rf_rdata_b;
    cpu_pkg::reg_idx_t src_a;
    cpu_pkg::reg_idx_t src_b;
    logic              uses_rx;
    logic              uses_ry;
    logic              dec_is_branch;
    cpu_pkg::decoded_t dec_out;
    cpu_pkg::stage_t   exe_out;
    cpu_pkg::stage_t   mem_out;
    logic              stall_decode;
    logic              flush_fetch;
    logic              mem_busy;       // memory stage waiting on DataDone
    logic              branch_done;
    cpu_pkg::word_t    branch_target;
    logic              wb_en;
    cpu_pkg::reg_idx_t wb_addr;
    cpu_pkg::word_t    wb_data;

    fetch_unit u_fetch (
        .Clock(Clock), .Reset(Reset), .InstrIn(InstrIn),
        .stall(stall_decode), .hold(mem_busy), .flush_fetch(flush_fetch),
        .branch_done(branch_done), .branch_target(branch_target),
        .InstrAddr(InstrAddr), .fetch_word(fetch_word), .fetch_pc(fetch_pc)
    );

    instr_decoder u_decode (
        .Clock(Clock), .Reset(Reset), .fetch_word(fetch_word), .fetch_pc(fetch_pc),
        .rf_rdata_a(rf_rdata_a), .rf_rdata_b(rf_rdata_b),
        .stall_decode(stall_decode), .hold(mem_busy),
        .rf_raddr_a(rf_raddr_a), .rf_raddr_b(rf_raddr_b),
        .src_a(src_a), .src_b(src_b), .uses_rx(uses_rx), .uses_ry(uses_ry),
        .dec_is_branch(dec_is_branch), .dec_out(dec_out)
    );

    hazard_unit u_hazard (
        .src_a(src_a), .src_b(src_b), .uses_rx(uses_rx), .uses_ry(uses_ry),
        .dec_is_branch(dec_is_branch),
        .dec_wb(dec_out.writeback), .dec_rx(dec_out.rx), .dec_br(dec_out.is_branch),
        .exe_wb(exe_out.writeback), .exe_rx(exe_out.rx), .exe_br(exe_out.is_branch),
        .mem_wb(mem_out.writeback), .mem_rx(mem_out.rx), .mem_br(mem_out.is_branch),
        .stall_decode(stall_decode), .flush_fetch(flush_fetch)
    );

    register_file u_regs (
        .Clock(Clock), .Reset(Reset),
        .raddr_a(rf_raddr_a), .raddr_b(rf_raddr_b),
        .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data),
        .rdata_a(rf_rdata_a), .rdata_b(rf_rdata_b)
    );

    execute_unit u_execute (
        .Clock(Clock), .Reset(Reset), .dec_out(dec_out), .hold(mem_busy),
        .exe_out(exe_out), .branch_done(branch_done), .branch_target(branch_target)
    );

    memory_stage u_memory (
        .Clock(Clock), .Reset(Reset), .exe_out(exe_out),
        .DataIn(DataIn), .DataDone(DataDone),
        .DataAddr(DataAddr), .DataOut(DataOut),
        .ReadData(ReadData), .WriteData(WriteData),
        .mem_busy(mem_busy), .mem_out(mem_out),
        .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data)
    );

endmodule

//--- src/execute_unit.sv
// execute stage: ALU, NZC flag register and branch resolution
// a branch in this stage reports its resume address on branch_done
`timescale 1ns/10ps

module execute_unit (
    input  logic              Clock,
    input  logic              Reset,
    input  cpu_pkg::decoded_t dec_out,
    input  logic              hold,
    output cpu_pkg::stage_t   exe_out,
    output logic              branch_done,
    output cpu_pkg::word_t    branch_target
);

    logic [cpu_pkg::WORD_SIZE:0] sum; // top bit is carry, or borrow for sub
    cpu_pkg::flags_t             flags_q;
    logic                        cond_met;
    cpu_pkg::stage_t             exe_next;

    always_comb begin
        case (dec_out.alu_op)
            cpu_pkg::ALU_ADD: sum = {1'b0, dec_out.op1} + {1'b0, dec_out.op2};
            cpu_pkg::ALU_SUB: sum = {1'b0, dec_out.op1} - {1'b0, dec_out.op2};
            default:          sum = {1'b0, dec_out.op2};
        endcase
    end

    always_comb begin
        case (dec_out.cond)
            cpu_pkg::COND_EQ: cond_met = flags_q.zero;
            cpu_pkg::COND_NE: cond_met = !flags_q.zero;
            cpu_pkg::COND_CC: cond_met = !flags_q.carry;
            cpu_pkg::COND_CS: cond_met = flags_q.carry;
            cpu_pkg::COND_PL: cond_met = !flags_q.zero && !flags_q.negative;
            cpu_pkg::COND_MI: cond_met = !flags_q.zero && flags_q.negative;
            default:          cond_met = 1'b1;
        endcase
    end

    assign branch_done   = dec_out.valid && dec_out.is_branch && !hold;
    assign branch_target = cond_met ? sum[cpu_pkg::WORD_SIZE-1:0] : dec_out.op1;

    always_comb begin
        exe_next            = '0;
        exe_next.valid      = dec_out.valid;
        exe_next.is_branch  = dec_out.is_branch;
        exe_next.writeback  = dec_out.writeback;
        exe_next.rx         = dec_out.rx;
        exe_next.read       = dec_out.read;
        exe_next.write      = dec_out.write;
        exe_next.result     = sum[cpu_pkg::WORD_SIZE-1:0];
        exe_next.store_data = dec_out.op1; // rX value for st
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            exe_out <= '0;
            flags_q <= '0;
        end else if (!hold) begin
            exe_out <= exe_next;
            if (dec_out.valid && dec_out.update_flags) begin
                flags_q.negative <= sum[cpu_pkg::WORD_SIZE-1];
                flags_q.zero     <= (sum[cpu_pkg::WORD_SIZE-1:0] == '0);
                flags_q.carry    <= sum[cpu_pkg::WORD_SIZE];
            end
        end
    end

endmodule

//--- src/fetch_unit.sv
// fetch stage: program counter and fetch register
// instruction memory is read combinationally at InstrAddr
`timescale 1ns/10ps

module fetch_unit (
    input  logic           Clock,
    input  logic           Reset,
    input  cpu_pkg::word_t InstrIn,
    input  logic           stall,         // decode stall, fetch holds
    input  logic           hold,          // memory back-pressure
    input  logic           flush_fetch,
    input  logic           branch_done,
    input  cpu_pkg::word_t branch_target,
    output cpu_pkg::word_t InstrAddr,
    output cpu_pkg::word_t fetch_word,
    output cpu_pkg::word_t fetch_pc
);

    cpu_pkg::word_t pc;

    assign InstrAddr = pc;

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            pc         <= '0;
            fetch_word <= '0;
            fetch_pc   <= '0;
        end else if (branch_done) begin
            pc <= branch_target; // resume address, taken or not
        end else if (!hold && !stall) begin
            if (flush_fetch) begin
                fetch_word <= '0; // the zero word decodes as a no-op
            end else begin
                fetch_word <= InstrIn;
                fetch_pc   <= pc;
                pc         <= pc + 1'b1;
            end
        end
    end

endmodule

//--- src/hazard_unit.sv
// hazard detection for the pipeline, no forwarding
// stalls decode on read-after-write against any pending register write
// and freezes fetch while a branch travels down the pipe
`timescale 1ns/10ps

module hazard_unit (
    input  cpu_pkg::reg_idx_t src_a,
    input  cpu_pkg::reg_idx_t src_b,
    input  logic              uses_rx,
    input  logic              uses_ry,
    input  logic              dec_is_branch,  // branch sitting in fetch register
    input  logic              dec_wb,
    input  cpu_pkg::reg_idx_t dec_rx,
    input  logic              dec_br,
    input  logic              exe_wb,
    input  cpu_pkg::reg_idx_t exe_rx,
    input  logic              exe_br,
    input  logic              mem_wb,
    input  cpu_pkg::reg_idx_t mem_rx,
    input  logic              mem_br,
    output logic              stall_decode,
    output logic              flush_fetch
);

    logic raw;
    logic branch_in_flight;

    function automatic logic pending(input cpu_pkg::reg_idx_t src);
        return (dec_wb && dec_rx == src) || (exe_wb && exe_rx == src) ||
               (mem_wb && mem_rx == src);
    endfunction

    assign raw              = (uses_rx && pending(src_a)) || (uses_ry && pending(src_b));
    assign branch_in_flight = dec_br || exe_br || mem_br;

    // the branch itself still moves from fetch into decode
    assign stall_decode = raw || branch_in_flight;
    assign flush_fetch  = dec_is_branch || branch_in_flight;

endmodule

//--- src/instr_decoder.sv
// decode stage: splits the fetched word, reads operands from the register
// file and loads the decode register that feeds execute
// source indices and use bits go to the hazard unit
`timescale 1ns/10ps

module instr_decoder (
    input  logic              Clock,
    input  logic              Reset,
    input  cpu_pkg::word_t    fetch_word,
    input  cpu_pkg::word_t    fetch_pc,
    input  cpu_pkg::word_t    rf_rdata_a,
    input  cpu_pkg::word_t    rf_rdata_b,
    input  logic              stall_decode,
    input  logic              hold,
    output cpu_pkg::reg_idx_t rf_raddr_a,
    output cpu_pkg::reg_idx_t rf_raddr_b,
    output cpu_pkg::reg_idx_t src_a,
    output cpu_pkg::reg_idx_t src_b,
    output logic              uses_rx,
    output logic              uses_ry,
    output logic              dec_is_branch,
    output cpu_pkg::decoded_t dec_out
);

    cpu_pkg::opcode_t  opcode;
    logic              imm_flag;
    cpu_pkg::reg_idx_t rx;
    cpu_pkg::reg_idx_t ry;
    cpu_pkg::word_t    imm_ext;
    logic              legal;
    cpu_pkg::decoded_t dec_next;

    assign opcode   = cpu_pkg::opcode_t'(fetch_word[15:13]);
    assign imm_flag = fetch_word[12];
    assign rx       = fetch_word[11:9];
    assign ry       = fetch_word[2:0];
    assign imm_ext  = {{(cpu_pkg::WORD_SIZE-cpu_pkg::IMM_BITS){fetch_word[cpu_pkg::IMM_BITS-1]}},
                       fetch_word[cpu_pkg::IMM_BITS-1:0]};

    // zero word, opcode 110 and malformed register-form 111 are empty slots
    assign legal = (fetch_word != '0) && (fetch_word[15:13] != 3'b110) &&
                   !((opcode == cpu_pkg::OP_CMP) && !imm_flag && (fetch_word[8:3] != '0));

    assign rf_raddr_a    = rx;
    assign rf_raddr_b    = ry;
    assign src_a         = rx;
    assign src_b         = ry;
    assign dec_is_branch = dec_next.is_branch;

    always_comb begin
        dec_next = '0;
        uses_rx  = 1'b0;
        uses_ry  = 1'b0;
        if (legal) begin
            dec_next.valid = 1'b1;
            dec_next.rx    = rx;
            dec_next.op1   = rf_rdata_a;
            dec_next.op2   = imm_flag ? imm_ext : rf_rdata_b;
            uses_ry        = !imm_flag;
            case (opcode)
                cpu_pkg::OP_MV: begin
                    dec_next.alu_op    = cpu_pkg::ALU_PASS;
                    dec_next.writeback = 1'b1;
                end
                cpu_pkg::OP_ADD, cpu_pkg::OP_SUB: begin
                    dec_next.alu_op    = (opcode == cpu_pkg::OP_ADD) ? cpu_pkg::ALU_ADD
                                                                     : cpu_pkg::ALU_SUB;
                    dec_next.writeback = 1'b1;
                    uses_rx            = 1'b1;
                end
                cpu_pkg::OP_LD: begin
                    dec_next.alu_op    = cpu_pkg::ALU_PASS; // op2 is the address
                    dec_next.writeback = 1'b1;
                    dec_next.read      = 1'b1;
                end
                cpu_pkg::OP_ST: begin
                    dec_next.alu_op = cpu_pkg::ALU_PASS;
                    dec_next.write  = 1'b1;
                    uses_rx         = 1'b1;  // store data
                end
                cpu_pkg::OP_CMP: begin
                    dec_next.alu_op       = cpu_pkg::ALU_SUB;
                    dec_next.update_flags = 1'b1;
                    uses_rx               = 1'b1;
                end
                cpu_pkg::OP_BCC: begin
                    // target = address after the branch + offset
                    dec_next.alu_op    = cpu_pkg::ALU_ADD;
                    dec_next.op1       = fetch_pc + 1'b1;
                    dec_next.op2       = imm_ext;
                    dec_next.cond      = cpu_pkg::cond_t'(rx);
                    dec_next.is_branch = 1'b1;
                    uses_ry            = 1'b0;
                end
                default: dec_next = '0;
            endcase
        end
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            dec_out <= '0;
        end else if (!hold) begin
            dec_out <= stall_decode ? '0 : dec_next; // bubble into execute on stall
        end
    end

endmodule

//--- src/memory_stage.sv
// memory stage: drives the data bus from its register and waits for DataDone
// also the register write port, which fires as the instruction leaves
`timescale 1ns/10ps

module memory_stage (
    input  logic              Clock,
    input  logic              Reset,
    input  cpu_pkg::stage_t   exe_out,
    input  cpu_pkg::word_t    DataIn,
    input  logic              DataDone,
    output cpu_pkg::word_t    DataAddr,
    output cpu_pkg::word_t    DataOut,
    output logic              ReadData,
    output logic              WriteData,
    output logic              mem_busy,
    output cpu_pkg::stage_t   mem_out,   // stage register, seen by hazard logic
    output logic              wb_en,
    output cpu_pkg::reg_idx_t wb_addr,
    output cpu_pkg::word_t    wb_data
);

    logic access;

    assign access   = mem_out.valid && (mem_out.read || mem_out.write);
    assign mem_busy = access && !DataDone; // DataDone ignored with no access

    // bus levels stay put while the register holds
    assign ReadData  = mem_out.valid && mem_out.read;
    assign WriteData = mem_out.valid && mem_out.write;
    assign DataAddr  = access ? mem_out.result : '0;
    assign DataOut   = WriteData ? mem_out.store_data : '0;

    assign wb_en   = mem_out.valid && mem_out.writeback && !mem_busy;
    assign wb_addr = mem_out.rx;
    assign wb_data = mem_out.read ? DataIn : mem_out.result; // load data sampled on DataDone

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            mem_out <= '0;
        end else if (!mem_busy) begin
            mem_out <= exe_out;
        end
    end

endmodule

//--- src/register_file.sv
// eight general registers, two combinational read ports, one write port
// reads return the value before a write at the same edge
`timescale 1ns/10ps

module register_file (
    input  logic              Clock,
    input  logic              Reset,
    input  cpu_pkg::reg_idx_t raddr_a,
    input  cpu_pkg::reg_idx_t raddr_b,
    input  logic              wb_en,
    input  cpu_pkg::reg_idx_t wb_addr,
    input  cpu_pkg::word_t    wb_data,
    output cpu_pkg::word_t    rdata_a,
    output cpu_pkg::word_t    rdata_b
);

    cpu_pkg::word_t regs [cpu_pkg::NUM_REGS];

    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_addr] <= wb_data;
        end
    end

endmodule
